// File: compile.f
+incdir+rtl
rtl/ad9866_pkg.sv
rtl/ad9866_cmd_decoder.sv
rtl/ad9866_init_sequencer.sv
rtl/ad9866_spi_shifter.sv
rtl/ad9866_ctrl.sv
verification/ad9866_ctrl_tb.sv

// File: Bender.yml
package:
  name: ad9866_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ad9866_pkg.sv
      - rtl/ad9866_cmd_decoder.sv
      - rtl/ad9866_init_sequencer.sv
      - rtl/ad9866_spi_shifter.sv
      - rtl/ad9866_ctrl.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/ad9866_ctrl_tb.sv

// File: verification/ad9866_ctrl_tb.sv
// ==========================================================
// AD9866 control testbench
// Power-up image, gain and raw write commands
// Every SPI frame checked in order against a reference model
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "ad9866_params.svh"

module ad9866_ctrl_tb;

  localparam int INIT_FRAMES = 9;
  localparam int N_TX        = 8;  // Random tx gains each sent twice
  localparam int N_RX        = 6;  // Random rx gains after the fixed three
  localparam int N_WR        = 6;
  localparam int N_BAD_KEY   = 2;
  localparam int N_OTHER     = 6;  // Addresses the decoder ignores
  localparam int N_CMDS      = 2 + 2 * N_TX + 3 + N_RX + 1 + N_WR + N_BAD_KEY + N_OTHER;
  localparam int TIMEOUT     = 40 * (INIT_FRAMES + N_CMDS) + 200;  // At most one frame per cmd

  logic                   clk = 1'b0;
  logic                   rst;
  ad9866_pkg::cmd_t       cmd;
  logic                   cmd_req;
  logic                   cmd_ack;
  logic                   sen_n;
  logic                   sclk;
  logic                   sdio;

  ad9866_pkg::spi_word_t  exp_q[$];    // Frames still due with the oldest first
  logic [3:0]             tx_model;    // Gains the chip should hold
  logic [6:0]             rx_model;
  logic [31:0]            rng = 32'hfce9_9c86;
  int                     frame_count = 0;
  int                     cycles = 0;
  ad9866_pkg::dec_state_e dec_state;  // Decoder state shown on timeout

  // SPI monitor state
  logic                   mon_sen_q = 1'b1;
  logic                   mon_sclk_q = 1'b0;
  int                     mon_len = 0;    // Cycles with sen_n low
  int                     mon_nbits = 0;
  ad9866_pkg::spi_word_t  mon_word;
  ad9866_pkg::spi_word_t  mon_exp;

  ad9866_ctrl ad9866_ctrl_i (
    .clk(clk), .rst(rst), .cmd(cmd), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
    .sen_n(sen_n), .sclk(sclk), .sdio(sdio)
  );

  always #5 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input ad9866_pkg::spi_word_t exp, input ad9866_pkg::spi_word_t act);
    if (act !== exp)
      stop_on_error($sformatf("mismatch at %0t ns: expected %04h (reg %02h = %02h), got %04h",
                              $time, exp, exp.reg_addr, exp.value, act));
  endtask

  // Frame with nothing due, or bus quiet with frames still due
  task automatic check_idle(input logic frame_seen, input ad9866_pkg::spi_word_t act);
    if (frame_seen && exp_q.size() == 0)
      stop_on_error($sformatf("frame to reg %02h value %02h at %0t ns while no write was due",
                              act.reg_addr, act.value, $time));
    else if (!frame_seen && exp_q.size() != 0)
      stop_on_error($sformatf("bus quiet at %0t ns with %0d expected frames never sent",
                              $time, exp_q.size()));
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic ad9866_pkg::cmd_t make_cmd(input logic [5:0] a, input logic [31:0] d);
    ad9866_pkg::cmd_t c;
    c.addr = a;
    c.data = d;
    return c;
  endfunction

  // Expected frame for one command and the gain model update
  function automatic logic ad9866_expect(input ad9866_pkg::cmd_t c,
                                         output ad9866_pkg::spi_word_t w);
    logic [5:0] code;
    logic       due;
    due = 1'b0;
    w   = '0;
    if (c.addr == `AD9866_ADDR_TXGAIN && c.data[31:28] != tx_model) begin
      tx_model   = c.data[31:28];
      w.reg_addr = `AD9866_REG_TXGAIN;
      w.value    = {4'b0100, tx_model};
      due        = 1'b1;
    end else if (c.addr == `AD9866_ADDR_RXGAIN && c.data[6:0] != rx_model) begin
      rx_model = c.data[6:0];
      if (rx_model[6])
        code = rx_model[5:0];
      else if (rx_model[5])
        code = 6'h3f - rx_model[5:0];           // Mid range counts down
      else
        code = 6'h20 | {1'b0, rx_model[4:0]};
      w.reg_addr = `AD9866_REG_RXGAIN;
      w.value    = {2'b01, code};
      due        = 1'b1;
    end else if (c.addr == `AD9866_ADDR_WRITE && c.data[31:24] == `AD9866_WRITE_KEY) begin
      w.reg_addr = c.data[20:16];
      w.value    = c.data[7:0];
      due        = 1'b1;
    end
    return due;
  endfunction

  // Default power-up image in ascending register order
  task automatic push_init_image();
    logic [4:0] regs [INIT_FRAMES] = '{5'h06, 5'h07, 5'h0b, 5'h0c, 5'h0d,
                                       5'h0e, 5'h10, 5'h11, 5'h12};
    logic [7:0] vals [INIT_FRAMES] = '{8'h54, 8'h30, 8'h00, 8'h43, 8'h03,
                                       8'h81, 8'h80, 8'h00, 8'h00};
    for (int i = 0; i < INIT_FRAMES; i++)
      exp_q.push_back('{pad: 3'b000, reg_addr: regs[i], value: vals[i]});
  endtask

  // Four-phase host handshake
  task automatic send_cmd(input ad9866_pkg::cmd_t c);
    @(posedge clk);
    cmd     <= c;
    cmd_req <= 1'b1;
    do @(posedge clk); while (!cmd_ack);
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);
  endtask

  task automatic run_cmd(input ad9866_pkg::cmd_t c);
    ad9866_pkg::spi_word_t w;
    if (ad9866_expect(c, w))
      exp_q.push_back(w);
    send_cmd(c);
  endtask

  // Nothing may be left after 40 quiet cycles
  task automatic wait_drain();
    int quiet;
    quiet = 0;
    while (quiet < 40) begin
      @(posedge clk);
      quiet = sen_n ? quiet + 1 : 0;
    end
    check_idle(1'b0, '0);
  endtask

  // SPI monitor sampling sdio on each sclk rise
  always @(posedge clk) begin
    if (!rst) begin
      if (!sen_n) begin
        mon_len = mon_len + 1;
        if (sclk && !mon_sclk_q) begin
          mon_word  = {mon_word[14:0], sdio};
          mon_nbits = mon_nbits + 1;
        end
      end else if (!mon_sen_q) begin  // Frame just closed
        if (mon_len != 2 * `AD9866_SPI_BITS || mon_nbits != `AD9866_SPI_BITS)
          stop_on_error($sformatf("mismatch at %0t ns: frame of %0d cycles and %0d bits",
                                  $time, mon_len, mon_nbits));
        check_idle(1'b1, mon_word);
        mon_exp = exp_q.pop_front();
        check_word(mon_exp, mon_word);
        frame_count <= frame_count + 1;
        mon_len   = 0;
        mon_nbits = 0;
      end
      mon_sen_q  = sen_n;
      mon_sclk_q = sclk;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      dec_state = ad9866_ctrl_i.ad9866_cmd_decoder_i.state;
      stop_on_error($sformatf("timeout after %0d cycles, decoder stuck in %s",
                              cycles, dec_state.name()));
    end
  end

  initial begin
    ad9866_pkg::cmd_t c;
    logic [5:0]       a;
    rst      = 1'b1;
    cmd      = '0;
    cmd_req  = 1'b0;
    tx_model = '0;
    rx_model = `AD9866_RXGAIN_RESET;
    push_init_image();
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Both issued while the image is still going out
    run_cmd(make_cmd(`AD9866_ADDR_RXGAIN, 32'h0000_0040));  // Reset gain gives no frame
    run_cmd(make_cmd(`AD9866_ADDR_TXGAIN, 32'hb000_0000));
    if (frame_count < INIT_FRAMES)
      stop_on_error($sformatf("tx gain acknowledged after only %0d power-up frames",
                              frame_count));
    wait_drain();

    // Back to back tx gains where a repeat gives ack only
    for (int i = 0; i < N_TX; i++) begin
      rng = xorshift32(rng);
      c   = make_cmd(`AD9866_ADDR_TXGAIN, rng);
      run_cmd(c);
      run_cmd(c);
    end
    wait_drain();

    run_cmd(make_cmd(`AD9866_ADDR_RXGAIN, 32'h0000_0055));  // Bit 6 branch
    run_cmd(make_cmd(`AD9866_ADDR_RXGAIN, 32'h0000_002a));  // Bit 5 branch
    run_cmd(make_cmd(`AD9866_ADDR_RXGAIN, 32'h0000_0013));  // Low range
    for (int i = 0; i < N_RX; i++) begin
      rng = xorshift32(rng);
      c   = make_cmd(`AD9866_ADDR_RXGAIN, rng);
      run_cmd(c);
    end
    run_cmd(c);
    wait_drain();

    // Raw writes, bad keys and foreign addresses
    for (int i = 0; i < N_WR; i++) begin
      rng = xorshift32(rng);
      run_cmd(make_cmd(`AD9866_ADDR_WRITE, {`AD9866_WRITE_KEY, rng[23:0]}));
    end
    for (int i = 0; i < N_BAD_KEY; i++) begin
      rng = xorshift32(rng);
      run_cmd(make_cmd(`AD9866_ADDR_WRITE,
                       {`AD9866_WRITE_KEY ^ (rng[31:24] | 8'h01), rng[23:0]}));
    end
    for (int i = 0; i < N_OTHER; i++) begin
      rng = xorshift32(rng);
      a   = rng[5:0];
      if (a == `AD9866_ADDR_TXGAIN || a == `AD9866_ADDR_RXGAIN || a == `AD9866_ADDR_WRITE)
        a = a ^ 6'h20;  // Move off the decoded addresses
      run_cmd(make_cmd(a, {`AD9866_WRITE_KEY, rng[29:6]}));
    end
    wait_drain();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/ad9866_ctrl.sv
// ==========================================================
// AD9866 serial port control, top level
// Host commands and power-up image onto the 3-wire SPI
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module ad9866_ctrl #(
  parameter int FAST_LNA     = 0,
  parameter int BYPASS_VERSA = 0
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire ad9866_pkg::cmd_t cmd,
  input  wire logic             cmd_req,
  output logic                  cmd_ack,
  output logic                  sen_n,
  output logic                  sclk,
  output logic                  sdio
);

  ad9866_pkg::spi_word_t wr_word;  // Decoder to sequencer
  ad9866_pkg::spi_word_t word;     // Sequencer to shifter
  logic                  wr_req;
  logic                  wr_ack;
  logic                  start;
  logic                  busy;

  ad9866_cmd_decoder #(.FAST_LNA(FAST_LNA)) ad9866_cmd_decoder_i (
    .clk, .rst, .cmd, .cmd_req, .cmd_ack,
    .wr_word, .wr_req, .wr_ack
  );

  ad9866_init_sequencer #(
    .FAST_LNA    (FAST_LNA),
    .BYPASS_VERSA(BYPASS_VERSA)
  ) ad9866_init_sequencer_i (
    .clk, .rst, .wr_word, .wr_req, .wr_ack,
    .busy, .start, .word
  );

  ad9866_spi_shifter ad9866_spi_shifter_i (
    .clk, .rst, .start, .word, .busy, .sen_n, .sclk, .sdio
  );

endmodule

`default_nettype wire

// File: rtl/ad9866_spi_shifter.sv
// ==========================================================
// AD9866 SPI shifter
// One 16-bit write frame per start pulse, MSB first,
// sclk at half the system clock
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module ad9866_spi_shifter (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start,
  input  wire ad9866_pkg::spi_word_t word,
  output logic                       busy,
  output logic                       sen_n,
  output logic                       sclk,
  output logic                       sdio
);

  localparam int BITS  = $bits(ad9866_pkg::spi_word_t);
  localparam int CNT_W = $clog2(BITS);

  logic [BITS-1:0]  shift_reg;
  logic [CNT_W-1:0] bit_cnt;   // Bits left after the current one

  assign busy = ~sen_n;
  assign sdio = shift_reg[BITS-1] & ~sen_n;  // Parked low between frames

  always_ff @(posedge clk) begin
    if (rst) begin
      sen_n   <= 1'b1;
      sclk    <= 1'b0;
      bit_cnt <= '0;
    end else if (sen_n) begin
      if (start) begin
        sen_n   <= 1'b0;
        bit_cnt <= CNT_W'(BITS - 1);
      end
    end else if (!sclk) begin
      sclk <= 1'b1;  // Chip samples on this rise
    end else begin
      sclk    <= 1'b0;
      bit_cnt <= bit_cnt - CNT_W'(1);
      if (bit_cnt == '0)
        sen_n <= 1'b1;  // Last bit done
    end
  end

  // Data only moves on the falling sclk edge
  always_ff @(posedge clk) begin
    if (sen_n && start)
      shift_reg <= word;
    else if (!sen_n && sclk)
      shift_reg <= {shift_reg[BITS-2:0], 1'b0};
  end

  // Sequencer only starts an idle shifter
  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);
  // Setup and hold around the sclk rise
  a_sdio_sclk_low: assert property (@(posedge clk) disable iff (rst)
    !$stable(sdio) |-> !sclk);

endmodule

`default_nettype wire

// File: rtl/ad9866_init_sequencer.sv
// ==========================================================
// AD9866 init sequencer
// Writes the power-up register image, then forwards
// decoded command words to the SPI shifter
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "ad9866_params.svh"

module ad9866_init_sequencer #(
  parameter int FAST_LNA     = 0,
  parameter int BYPASS_VERSA = 0  // Chip clocked without the VersaClock
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire ad9866_pkg::spi_word_t wr_word,
  input  wire logic                  wr_req,
  output logic                       wr_ack,
  input  wire logic                  busy,
  output logic                       start,
  output ad9866_pkg::spi_word_t      word
);

  // Power-up image, slot index is the register address
  localparam ad9866_pkg::init_entry_t IMAGE [`AD9866_INIT_LEN] = '{
    '{1'b0, 8'h80},                  // 0x00 four-wire SPI, untouched
    '{1'b0, 8'h00},
    '{1'b0, 8'h00},
    '{1'b0, 8'h00},
    '{BYPASS_VERSA == 1, 8'h36},     // 0x04 PLL setup without external clock
    '{1'b0, 8'h00},
    '{1'b1, 8'h54},                  // 0x06 clkout2 off
    '{1'b1, 8'h30},                  // 0x07 DC offset cal, Rx filter on
    '{1'b0, 8'h4b},                  // 0x08 Rx filter corner, default kept
    '{1'b0, 8'h00},                  // 0x09 Rx gain, host owned
    '{1'b0, 8'h00},                  // 0x0a Tx gain, host owned
    '{1'b1, (FAST_LNA == 1) ? 8'h04 : 8'h00},  // 0x0b RxPGA update via Tx bus
    '{1'b1, 8'h43},                  // 0x0c Tx twos complement, interpolation
    '{1'b1, 8'h03},                  // 0x0d Rx twos complement
    '{1'b1, 8'h81},                  // 0x0e IAMP setup
    '{1'b0, 8'h00},
    '{1'b1, 8'h80},                  // 0x10 Tx gain select
    '{1'b1, 8'h00},
    '{1'b1, 8'h00},
    '{1'b0, 8'h00}
  };

  logic [4:0] init_ptr;   // Next image slot
  logic       init_done;
  logic       slot_free;  // Shifter idle, no pulse in flight
  logic       load_init;
  logic       load_cmd;

  assign init_done = (init_ptr == 5'(`AD9866_INIT_LEN));
  assign slot_free = !busy && !start;
  assign load_init = !init_done && slot_free && IMAGE[init_ptr].en;
  assign load_cmd  = init_done && slot_free && wr_req && !wr_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      init_ptr <= '0;
      start    <= 1'b0;
      wr_ack   <= 1'b0;
    end else begin
      start <= load_init || load_cmd;  // One-cycle pulse
      if (!init_done && slot_free)
        init_ptr <= init_ptr + 5'd1;   // Disabled slots just cost a cycle
      if (load_cmd)
        wr_ack <= 1'b1;
      else if (!wr_req)
        wr_ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_init)
      word <= '{pad: 3'b000, reg_addr: init_ptr, value: IMAGE[init_ptr].value};
    else if (load_cmd)
      word <= wr_word;
  end

endmodule

`default_nettype wire

// File: rtl/ad9866_cmd_decoder.sv
// ==========================================================
// AD9866 host command decoder
// Tx/Rx gain and raw register commands turned into SPI
// words, unchanged gains and unknown addresses just acked
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "ad9866_params.svh"

module ad9866_cmd_decoder #(
  parameter int FAST_LNA = 0  // Rx gain via Tx pins, no SPI writes
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire ad9866_pkg::cmd_t      cmd,
  input  wire logic                  cmd_req,
  output logic                       cmd_ack,
  output ad9866_pkg::spi_word_t      wr_word,
  output logic                       wr_req,
  input  wire logic                  wr_ack
);

  ad9866_pkg::dec_state_e state;
  ad9866_pkg::spi_word_t  new_word;
  logic [3:0]             tx_gain;     // Last gain sent to the chip
  logic [6:0]             rx_gain;
  logic                   need_write;
  logic                   accept;

  // Chip Rx gain code from the host 7-bit gain
  function automatic logic [5:0] rx_code(input logic [6:0] g);
    if (g[6])
      return g[5:0];
    else if (g[5])
      return ~g[5:0];  // Mid range is inverted
    else
      return {1'b1, g[4:0]};
  endfunction

  // New request, previous word handshake fully closed
  assign accept = (state == ad9866_pkg::IDLE) && cmd_req && !wr_ack;

  always_comb begin
    need_write = 1'b0;
    new_word   = '0;
    case (cmd.addr)
      `AD9866_ADDR_TXGAIN: begin
        if (cmd.data[31:28] != tx_gain) begin
          need_write = 1'b1;
          new_word   = '{pad: 3'b000, reg_addr: `AD9866_REG_TXGAIN,
                         value: {4'b0100, cmd.data[31:28]}};
        end
      end
      `AD9866_ADDR_RXGAIN: begin
        if (FAST_LNA == 0 && cmd.data[6:0] != rx_gain) begin
          need_write = 1'b1;
          new_word   = '{pad: 3'b000, reg_addr: `AD9866_REG_RXGAIN,
                         value: {2'b01, rx_code(cmd.data[6:0])}};
        end
      end
      `AD9866_ADDR_WRITE: begin
        if (cmd.data[31:24] == `AD9866_WRITE_KEY) begin
          need_write = 1'b1;
          new_word   = '{pad: 3'b000, reg_addr: cmd.data[20:16], value: cmd.data[7:0]};
        end
      end
      default: need_write = 1'b0;  // Not ours, ack only
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ad9866_pkg::IDLE;
      cmd_ack <= 1'b0;
      wr_req  <= 1'b0;
      tx_gain <= '0;
      rx_gain <= `AD9866_RXGAIN_RESET;
    end else begin
      case (state)
        ad9866_pkg::IDLE: begin
          if (accept) begin
            if (need_write) begin
              wr_req <= 1'b1;
              state  <= ad9866_pkg::ISSUE;
            end else begin
              state  <= ad9866_pkg::DONE;
            end
            // Remember what the chip now holds
            if (need_write && cmd.addr == `AD9866_ADDR_TXGAIN)
              tx_gain <= cmd.data[31:28];
            if (need_write && cmd.addr == `AD9866_ADDR_RXGAIN)
              rx_gain <= cmd.data[6:0];
          end
        end
        ad9866_pkg::ISSUE: if (wr_ack) state <= ad9866_pkg::DONE;  // Frame started
        ad9866_pkg::DONE: begin
          if (!cmd_ack) begin
            cmd_ack <= 1'b1;
          end else if (!cmd_req) begin  // Host closed, release both sides
            cmd_ack <= 1'b0;
            wr_req  <= 1'b0;
            state   <= ad9866_pkg::IDLE;
          end
        end
        default: state <= ad9866_pkg::IDLE;
      endcase
    end
  end

  // Word only loaded when a write is decided
  always_ff @(posedge clk) begin
    if (accept && need_write) wr_word <= new_word;
  end

  // Host never sees ack without a pending req
  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_ack) |-> cmd_req);
  // Word held for the whole sequencer handshake
  a_word_stable: assert property (@(posedge clk) disable iff (rst)
    ($past(wr_req) && wr_req) |-> $stable(wr_word));

endmodule

`default_nettype wire

// File: rtl/ad9866_pkg.sv
// ==========================================================
// AD9866 control types
// Host command, SPI frame, init image entry, decoder states
// ==========================================================
`default_nettype none

package ad9866_pkg;

  // One host command on the register-style bus
  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
  } cmd_t;

  // 16-bit SPI frame in shift order, pad bits go out first
  typedef struct packed {
    logic [2:0] pad;       // Always zero, write with 1-byte transfer
    logic [4:0] reg_addr;  // Chip register
    logic [7:0] value;
  } spi_word_t;

  // Power-up image slot
  typedef struct packed {
    logic       en;     // Slot gets written
    logic [7:0] value;
  } init_entry_t;

  // Command decoder states
  typedef enum logic [1:0] {
    IDLE,   // Waiting for host req
    ISSUE,  // Word offered to sequencer
    DONE    // Ack to host, wait for req low
  } dec_state_e;

endpackage

`default_nettype wire

// File: rtl/ad9866_params.svh
// ==========================================================
// AD9866 control constants
// Frame length, host command map, chip gain registers and
// the power-up image size
// ==========================================================
`ifndef AD9866_PARAMS_SVH
`define AD9866_PARAMS_SVH

// One SPI frame, MSB first
`define AD9866_SPI_BITS 16
// Power-up image covers registers 0x00..0x13
`define AD9866_INIT_LEN 20

// Host command addresses
`define AD9866_ADDR_TXGAIN 6'h09
`define AD9866_ADDR_RXGAIN 6'h0a
`define AD9866_ADDR_WRITE  6'h3b
`define AD9866_WRITE_KEY   8'h06  // Required in data[31:24] for a raw write

// Chip side gain registers (note the crossed numbering)
`define AD9866_REG_TXGAIN 5'h0a
`define AD9866_REG_RXGAIN 5'h09

// Rx gain held after reset, matches chip default
`define AD9866_RXGAIN_RESET 7'h40

`endif
